// File: Makefile
# Verilator simulation of the memory request bridge

VERILATOR ?= verilator
TOP       ?= memreq_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/mem_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "memreq_config.svh"

module mem_engine
  import memreq_pkg::*;
(
  input  wire           bus_clock,
  input  wire           bus_reset,
  input  wire req_cmd_t cmd_entry,
  input  wire           cmd_empty,
  output logic          cmd_pop,
  input  wire  [7:0]    data_byte,
  input  wire           data_empty,
  output logic          data_pop,
  input  wire           resp_full,
  output logic          resp_push,
  output resp_beat_t    resp_beat
);

  localparam int MEM_AW = $clog2(`MEMREQ_MEM_BYTES);
  localparam int AW1    = `MEMREQ_ADDRESS_WIDTH + 1;

  localparam logic [4:0] S_IDLE  = 5'b00001;
  localparam logic [4:0] S_DRAIN = 5'b00010;
  localparam logic [4:0] S_HDR   = 5'b00100;
  localparam logic [4:0] S_ID    = 5'b01000;
  localparam logic [4:0] S_DATA  = 5'b10000;

  logic [4:0]        state;
  req_cmd_t          cmd_q;
  logic              ok_q;   // Address range fits the memory
  logic [7:0]        cnt_q;
  logic [MEM_AW-1:0] ptr_q;
  logic [7:0]        mem [`MEMREQ_MEM_BYTES];
  logic [AW1-1:0]    end_addr;
  logic              in_range;
  logic              store_ok;

  assign end_addr = {1'b0, cmd_entry.addr} + AW1'(cmd_entry.len);
  assign in_range = end_addr <= AW1'(`MEMREQ_MEM_BYTES);
  assign store_ok = ok_q && cmd_q.complete;

  assign cmd_pop   = state == S_IDLE && !cmd_empty;
  assign data_pop  = state == S_DRAIN && !data_empty;
  assign resp_push = (state == S_HDR || state == S_ID || state == S_DATA) && !resp_full;

  always_comb begin
    resp_beat = '0;
    case (state)
      S_HDR: begin
        if (cmd_q.is_fetch) resp_beat.data = ok_q ? CMD_RDATA : CMD_RFAIL;
        else resp_beat.data = store_ok ? CMD_WDONE : CMD_WFAIL;
      end
      S_ID: begin
        resp_beat.last = !(cmd_q.is_fetch && ok_q);
        resp_beat.data = {cmd_q.id, 4'h0};
      end
      S_DATA: begin
        resp_beat.last = cnt_q == 8'd1;
        resp_beat.data = mem[ptr_q];
      end
      default: ;
    endcase
  end

  // ========================================
  // Command sequencing
  // ========================================

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_pop) begin
            // STORE data is drained even when it will not be written
            if (!cmd_entry.is_fetch && cmd_entry.rcv_len != 8'd0) state <= S_DRAIN;
            else state <= S_HDR;
          end
        end
        S_DRAIN: if (data_pop && cnt_q == 8'd1) state <= S_HDR;
        S_HDR:   if (resp_push) state <= S_ID;
        S_ID: begin
          if (resp_push) state <= (cmd_q.is_fetch && ok_q) ? S_DATA : S_IDLE;
        end
        S_DATA:  if (resp_push && cnt_q == 8'd1) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (cmd_pop) begin
      cmd_q <= cmd_entry;
      ok_q  <= in_range;
      ptr_q <= cmd_entry.addr[MEM_AW-1:0];
      cnt_q <= cmd_entry.is_fetch ? cmd_entry.len : cmd_entry.rcv_len;
    end else if (data_pop || (state == S_DATA && resp_push)) begin
      ptr_q <= ptr_q + 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (data_pop && store_ok) begin
      mem[ptr_q] <= data_byte;  // Failed stores leave memory alone
    end
  end

  // Write bytes are consumed only on behalf of a STORE with bytes outstanding
  a_drain_store: assert property (@(posedge bus_clock) disable iff (bus_reset)
    data_pop |-> !cmd_q.is_fetch && cnt_q != 8'd0);

endmodule

`default_nettype wire

// File: hdl/memreq_config.svh
`ifndef MEMREQ_CONFIG_SVH
`define MEMREQ_CONFIG_SVH

// Request address width in bits
`define MEMREQ_ADDRESS_WIDTH 28

// Transaction ID width, carried in the upper nibble of byte 5
`define MEMREQ_ID_WIDTH 4

// Entries per FIFO, a power of two
`define MEMREQ_FIFO_DEPTH 16

// Size of the engine memory in bytes
`define MEMREQ_MEM_BYTES 1024

`endif

// File: hdl/memreq_pkg.sv
`default_nettype none

`include "memreq_config.svh"

package memreq_pkg;

  // Request command codes
  parameter logic [7:0] CMD_STORE = 8'h01;
  parameter logic [7:0] CMD_FETCH = 8'h80;

  // Response codes
  parameter logic [7:0] CMD_WDONE = 8'h02;
  parameter logic [7:0] CMD_WFAIL = 8'h03;
  parameter logic [7:0] CMD_RDATA = 8'h81;
  parameter logic [7:0] CMD_RFAIL = 8'h82;

  // One parsed request as it sits in the command FIFO
  typedef struct packed {
    logic                             is_fetch;
    logic [`MEMREQ_ID_WIDTH-1:0]      id;
    logic [`MEMREQ_ADDRESS_WIDTH-1:0] addr;
    logic [7:0]                       len;
    logic [7:0]                       rcv_len;   // Write bytes actually pushed
    logic                             complete;  // STORE got all of its bytes
  } req_cmd_t;

  // One byte of an outgoing response frame
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } resp_beat_t;

endpackage

`default_nettype wire

// File: hdl/memreq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "memreq_config.svh"

module memreq_top
  import memreq_pkg::*;
(
  input  wire        bus_clock,
  input  wire        bus_reset,
  input  wire        s_tvalid,
  output logic       s_tready,
  input  wire        s_tkeep,
  input  wire        s_tlast,
  input  wire  [7:0] s_tdata,
  output logic       m_tvalid,
  input  wire        m_tready,
  output logic       m_tlast,
  output logic [7:0] m_tdata
);

  req_cmd_t   cmd_wr, cmd_rd;
  logic       cmd_push, cmd_full, cmd_pop, cmd_empty;
  logic [7:0] data_wr, data_rd;
  logic       data_push, data_full, data_pop, data_empty;
  resp_beat_t resp_wr, resp_rd;
  logic       resp_push, resp_full, resp_pop, resp_empty;

  req_splitter u_splitter (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tkeep(s_tkeep),
    .s_tlast(s_tlast), .s_tdata(s_tdata),
    .cmd_full(cmd_full), .cmd_push(cmd_push), .cmd_entry(cmd_wr),
    .data_full(data_full), .data_push(data_push), .data_byte(data_wr)
  );

  sync_fifo #(.payload_t(req_cmd_t), .DEPTH(`MEMREQ_FIFO_DEPTH)) u_cmd_fifo (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .push(cmd_push), .wdata(cmd_wr), .full(cmd_full),
    .pop(cmd_pop), .rdata(cmd_rd), .empty(cmd_empty)
  );

  // A whole STORE payload has to fit, as its command only follows the last data byte
  sync_fifo #(.payload_t(logic [7:0]), .DEPTH(256)) u_data_fifo (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .push(data_push), .wdata(data_wr), .full(data_full),
    .pop(data_pop), .rdata(data_rd), .empty(data_empty)
  );

  mem_engine u_engine (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .cmd_entry(cmd_rd), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
    .data_byte(data_rd), .data_empty(data_empty), .data_pop(data_pop),
    .resp_full(resp_full), .resp_push(resp_push), .resp_beat(resp_wr)
  );

  sync_fifo #(.payload_t(resp_beat_t), .DEPTH(`MEMREQ_FIFO_DEPTH)) u_resp_fifo (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .push(resp_push), .wdata(resp_wr), .full(resp_full),
    .pop(resp_pop), .rdata(resp_rd), .empty(resp_empty)
  );

  // Response FIFO head is the outgoing stream
  assign m_tvalid = !resp_empty;
  assign m_tlast  = resp_rd.last;
  assign m_tdata  = resp_rd.data;
  assign resp_pop = m_tready && !resp_empty;

endmodule

`default_nettype wire

// File: hdl/req_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module req_splitter
  import memreq_pkg::*;
(
  input  wire        bus_clock,
  input  wire        bus_reset,
  input  wire        s_tvalid,
  output logic       s_tready,
  input  wire        s_tkeep,
  input  wire        s_tlast,
  input  wire  [7:0] s_tdata,
  input  wire        cmd_full,
  output logic       cmd_push,
  output req_cmd_t   cmd_entry,
  input  wire        data_full,
  output logic       data_push,
  output logic [7:0] data_byte
);

  localparam logic [7:0] S_IDLE    = 8'b0000_0001;
  localparam logic [7:0] S_LEN     = 8'b0000_0010;
  localparam logic [7:0] S_ADR0    = 8'b0000_0100;
  localparam logic [7:0] S_ADR1    = 8'b0000_1000;
  localparam logic [7:0] S_ADR2    = 8'b0001_0000;
  localparam logic [7:0] S_IDAD    = 8'b0010_0000;
  localparam logic [7:0] S_DATA    = 8'b0100_0000;
  localparam logic [7:0] S_DISCARD = 8'b1000_0000;

  logic [7:0]  state;
  logic        is_fetch_q;
  logic [7:0]  len_q;
  logic [23:0] addr_q;
  logic [7:0]  idad_q;  // ID nibble and address bits 27:24
  logic [7:0]  cnt_q;   // Write bytes still expected
  logic [7:0]  rcv_q;   // Write bytes pushed so far
  logic        xfer;
  logic        kept;
  logic        last_data;

  assign s_tready  = !data_full && !cmd_full;
  assign xfer      = s_tvalid && s_tready;
  assign kept      = xfer && s_tkeep;
  assign last_data = kept && state == S_DATA && cnt_q == 8'd1;

  assign data_push = kept && state == S_DATA;
  assign data_byte = s_tdata;

  // A FETCH closes on byte 5, a STORE on its final data byte or an early last marker
  assign cmd_push = (state == S_IDAD && kept && (is_fetch_q || s_tlast)) ||
                    (state == S_DATA && xfer && (s_tlast || last_data));

  always_comb begin
    cmd_entry.is_fetch = is_fetch_q;
    cmd_entry.len      = len_q;
    if (state == S_IDAD) begin  // Byte 5 is still on the bus
      cmd_entry.id       = s_tdata[7:4];
      cmd_entry.addr     = {s_tdata[3:0], addr_q};
      cmd_entry.rcv_len  = 8'd0;
      cmd_entry.complete = 1'b0;
    end else begin
      cmd_entry.id       = idad_q[7:4];
      cmd_entry.addr     = {idad_q[3:0], addr_q};
      cmd_entry.rcv_len  = rcv_q + {7'd0, data_push};
      cmd_entry.complete = last_data;
    end
  end

  // ========================================
  // Frame FSM
  // ========================================

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state <= S_IDLE;
    end else if (xfer) begin
      case (state)
        S_IDLE: begin
          if (s_tkeep && !s_tlast) begin
            state <= (s_tdata == CMD_STORE || s_tdata == CMD_FETCH) ? S_LEN : S_DISCARD;
          end
        end
        S_LEN: begin
          if (s_tlast) state <= S_IDLE;  // Truncated header, dropped
          else if (s_tkeep) state <= S_ADR0;
        end
        S_ADR0: begin
          if (s_tlast) state <= S_IDLE;
          else if (s_tkeep) state <= S_ADR1;
        end
        S_ADR1: begin
          if (s_tlast) state <= S_IDLE;
          else if (s_tkeep) state <= S_ADR2;
        end
        S_ADR2: begin
          if (s_tlast) state <= S_IDLE;
          else if (s_tkeep) state <= S_IDAD;
        end
        S_IDAD: begin
          if (s_tlast) state <= S_IDLE;
          else if (s_tkeep) state <= is_fetch_q ? S_DISCARD : S_DATA;
        end
        S_DATA: begin
          if (s_tlast) state <= S_IDLE;
          else if (last_data) state <= S_DISCARD;  // Excess bytes up to the marker
        end
        S_DISCARD: begin
          if (s_tlast) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (kept) begin
      case (state)
        S_IDLE: is_fetch_q <= s_tdata == CMD_FETCH;
        S_LEN:  len_q <= s_tdata;
        S_ADR0: addr_q[7:0] <= s_tdata;
        S_ADR1: addr_q[15:8] <= s_tdata;
        S_ADR2: addr_q[23:16] <= s_tdata;
        S_IDAD: begin
          idad_q <= s_tdata;
          cnt_q  <= len_q;
          rcv_q  <= 8'd0;
        end
        S_DATA: begin
          cnt_q <= cnt_q - 1'b1;
          rcv_q <= rcv_q + 1'b1;
        end
        default: ;
      endcase
    end
  end

  a_cmd_room: assert property (@(posedge bus_clock) disable iff (bus_reset)
    cmd_push |-> !cmd_full);

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  wire           bus_clock,
  input  wire           bus_reset,
  input  wire           push,
  input  wire payload_t wdata,
  output logic          full,
  input  wire           pop,
  output payload_t      rdata,
  output logic          empty
);

  localparam int AW = $clog2(DEPTH);

  payload_t    mem [DEPTH];
  logic [AW:0] wr_ptr;  // Extra top bit tells full from empty
  logic [AW:0] rd_ptr;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (push && !full) begin
      mem[wr_ptr[AW-1:0]] <= wdata;
    end
  end

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign rdata = mem[rd_ptr[AW-1:0]];  // Head entry falls through

  // Producers and consumers must honour the flags
  a_no_overflow: assert property (@(posedge bus_clock) disable iff (bus_reset)
    push |-> !full);

  a_no_underflow: assert property (@(posedge bus_clock) disable iff (bus_reset)
    pop |-> !empty);

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/memreq_pkg.sv
hdl/sync_fifo.sv
hdl/req_splitter.sv
hdl/mem_engine.sv
hdl/memreq_top.sv
tb/memreq_tb.sv

// File: tb/memreq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memreq_config.svh"

module memreq_tb
  import memreq_pkg::*;
();

  localparam int NUM_FRAMES = 300;
  localparam int MEM_BYTES  = `MEMREQ_MEM_BYTES;
  // Each loop pass sends up to two frames of about 300 bytes at 4 ns, four times over
  localparam int WATCHDOG_NS = (2 * NUM_FRAMES + 8) * 300 * 4 * 4;

  logic       bus_clock = 1'b0;
  logic       bus_reset;
  logic       s_tvalid;
  logic       s_tready;
  logic       s_tkeep;
  logic       s_tlast;
  logic [7:0] s_tdata;
  logic       m_tvalid;
  logic       m_tready;
  logic       m_tlast;
  logic [7:0] m_tdata;

  logic [7:0] mem_model [MEM_BYTES];
  logic [7:0] frame_q [$];
  logic [8:0] expect_q [$];  // Last flag and data byte
  string      name_q [$];

  memreq_top i_dut (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tkeep(s_tkeep),
    .s_tlast(s_tlast), .s_tdata(s_tdata),
    .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast), .m_tdata(m_tdata)
  );

  always #2 bus_clock = ~bus_clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic bit in_range(input logic [27:0] addr, input logic [7:0] len);
    return longint'(addr) + longint'(len) <= longint'(MEM_BYTES);
  endfunction

  // Every fill byte depends on all ten address bits
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'((a >> 8) * 8'h55);
  endfunction

  function automatic logic [27:0] oob_addr(input logic [7:0] len);
    if ($urandom_range(0, 1) == 0) begin
      return 28'(MEM_BYTES - int'(len) + 1 + int'($urandom_range(0, 200)));
    end
    return 28'($urandom) | 28'h400;
  endfunction

  // ========================================
  // Input stream driver
  // ========================================

  task automatic drive_byte(input logic [7:0] data, input logic keep, input logic last);
    logic ready;
    ready = 1'b0;
    while ($urandom_range(0, 7) == 0) begin  // Idle gap on s_tvalid
      s_tvalid = 1'b0;
      @(posedge bus_clock);
      #0.5;
    end
    s_tvalid = 1'b1;
    s_tkeep  = keep;
    s_tlast  = last;
    s_tdata  = data;
    while (!ready) begin
      ready = s_tready;  // Registered flags, stable until the next edge
      @(posedge bus_clock);
      #0.5;
    end
    s_tvalid = 1'b0;
  endtask

  task automatic send_kept(input logic [7:0] data, input logic last);
    if ($urandom_range(0, 9) == 0) begin
      drive_byte(8'($urandom), 1'b0, 1'b0);  // Ignored filler byte
    end
    drive_byte(data, 1'b1, last);
  endtask

  task automatic send_frame();
    for (int i = 0; i < frame_q.size(); i++) begin
      send_kept(frame_q[i], i == frame_q.size() - 1);
    end
    frame_q.delete();
  endtask

  task automatic push_header(input logic [7:0] cmd, input logic [7:0] len,
                             input logic [27:0] addr, input logic [3:0] id);
    frame_q.push_back(cmd);
    frame_q.push_back(len);
    frame_q.push_back(addr[7:0]);
    frame_q.push_back(addr[15:8]);
    frame_q.push_back(addr[23:16]);
    frame_q.push_back({id, addr[27:24]});
  endtask

  task automatic queue_response(input logic [7:0] data, input logic last, input string name);
    expect_q.push_back({last, data});
    name_q.push_back(name);
  endtask

  // A STORE is written only when all L bytes came and the range fits
  task automatic store_frame(input logic [27:0] addr, input logic [7:0] len,
                             input logic [3:0] id, input int sent, input bit fill,
                             input string name);
    logic       ok;
    logic [7:0] d;
    ok = in_range(addr, len) && sent == int'(len);
    push_header(CMD_STORE, len, addr, id);
    for (int i = 0; i < sent; i++) begin
      d = fill ? fill_byte(int'(addr) + i) : 8'($urandom);
      frame_q.push_back(d);
      if (ok) mem_model[int'(addr) + i] = d;
    end
    queue_response(ok ? CMD_WDONE : CMD_WFAIL, 1'b0, name);
    queue_response({id, 4'h0}, 1'b1, name);
    send_frame();
  endtask

  task automatic fetch_frame(input logic [27:0] addr, input logic [7:0] len,
                             input logic [3:0] id, input string name);
    push_header(CMD_FETCH, len, addr, id);
    if (in_range(addr, len)) begin
      queue_response(CMD_RDATA, 1'b0, name);
      queue_response({id, 4'h0}, 1'b0, name);
      for (int i = 0; i < int'(len); i++) begin
        queue_response(mem_model[int'(addr) + i], i == int'(len) - 1, name);
      end
    end else begin
      queue_response(CMD_RFAIL, 1'b0, name);
      queue_response({id, 4'h0}, 1'b1, name);
    end
    send_frame();
  endtask

  // ========================================
  // Output monitor and watchdog
  // ========================================

  initial begin
    logic [8:0] exp;
    string      name;
    m_tready = 1'b0;
    @(negedge bus_reset);
    forever begin
      @(posedge bus_clock);
      #0.5;
      m_tready = $urandom_range(0, 3) != 0;
      if (m_tvalid && m_tready) begin
        if (expect_q.size() == 0) begin
          fail_run("Response byte arrived while no response was expected");
        end else begin
          exp  = expect_q.pop_front();
          name = name_q.pop_front();
          check_value(name, 32'(exp), 32'({m_tlast, m_tdata}));
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Timeout: the responses did not all arrive in time");
  end

  // ========================================
  // Stimulus
  // ========================================

  initial begin
    logic [27:0] addr;
    logic [7:0]  len;
    logic [7:0]  d;
    logic [3:0]  id;
    int          kind;
    int          n;
    int          a;
    void'($urandom(32'hb503));
    bus_reset = 1'b1;
    s_tvalid  = 1'b0;
    s_tkeep   = 1'b0;
    s_tlast   = 1'b0;
    s_tdata   = 8'h00;
    repeat (8) @(posedge bus_clock);
    #0.5;
    bus_reset = 1'b0;

    a = 0;
    while (a < MEM_BYTES) begin  // Known contents before any random FETCH
      n = (MEM_BYTES - a > 255) ? 255 : MEM_BYTES - a;
      store_frame(28'(a), 8'(n), 4'(a), n, 1'b1, "fill");
      a += n;
    end

    for (int f = 0; f < NUM_FRAMES; f++) begin
      kind = int'($urandom_range(0, 9));
      len  = 8'($urandom_range(1, 255));
      id   = 4'($urandom);
      addr = 28'($urandom_range(0, MEM_BYTES - int'(len)));
      case (kind)
        0, 1, 2, 3: begin
          store_frame(addr, len, id, int'(len), 1'b0, "store_ok");
          fetch_frame(addr, len, id, "fetch_after_store");
        end
        4: fetch_frame(addr, len, id, "fetch");
        5: begin
          n = int'($urandom_range(0, int'(len) - 1));
          store_frame(addr, len, id, n, 1'b0, "truncated_store");
          fetch_frame(addr, len, id, "fetch_after_truncated");
        end
        6: store_frame(oob_addr(len), len, id, int'(len), 1'b0, "range_store");
        7: fetch_frame(oob_addr(len), len, id, "range_fetch");
        8: begin
          d = 8'($urandom);
          while (d == CMD_STORE || d == CMD_FETCH) d = 8'($urandom);
          frame_q.push_back(d);
          n = int'($urandom_range(0, 8));
          repeat (n) frame_q.push_back(8'($urandom));
          send_frame();
        end
        default: begin  // Last marker inside the header
          frame_q.push_back(($urandom_range(0, 1) == 0) ? CMD_STORE : CMD_FETCH);
          n = int'($urandom_range(0, 4));
          repeat (n) frame_q.push_back(8'($urandom));
          send_frame();
        end
      endcase
    end

    while (expect_q.size() != 0) @(posedge bus_clock);
    repeat (64) @(posedge bus_clock);  // Nothing more may come out
    #0.5;
    if (m_tvalid !== 1'b0) begin
      fail_run("Output stream still valid after the last expected response");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
